// ==== verilog/fbw_pkg.sv ====
package fbw_pkg;

  typedef logic [31:0] fbw_addr_t;
  typedef logic [31:0] fbw_word_t;

  typedef logic [8:0] line_t;
  typedef logic [9:0] col_t;

  // Pixel view of a FIFO word, fields in bus order
  typedef struct packed {
    logic [6:0] pad_line;
    line_t      line;
    logic [5:0] pad_col;
    col_t       col;
    fbw_word_t  color;
    fbw_word_t  depth;
  } pix_frag_t;

  // Same 96 bits, seen as pixel or as marker
  typedef union packed {
    pix_frag_t   pix;
    logic [95:0] marker;
  } frag_u;

  localparam logic [95:0] FLUSH_MARKER = '1;

  // Depth-test lane states
  typedef enum logic [1:0] {
    LANE_IDLE  = 2'd0,
    LANE_RD_Z  = 2'd1,
    LANE_WR_FB = 2'd2,
    LANE_WR_Z  = 2'd3
  } lane_state_e;

  localparam int FLUSH_WORDS = 4;

endpackage

// ==== verilog/fbw_bus_if.sv ====
`timescale 1ns/1ps

interface fbw_bus_if;
  import fbw_pkg::*;

  logic      rd_req;
  logic      wr_req;
  fbw_addr_t addr;
  fbw_word_t wr_data;
  logic      cmd_ack;
  logic      cmplt;
  fbw_word_t rd_data;

  // Lanes and flush sequencer
  modport requester (
    output rd_req, wr_req, addr, wr_data,
    input  cmd_ack, cmplt, rd_data
  );

  modport arbiter (
    input  rd_req, wr_req, addr, wr_data,
    output cmd_ack, cmplt, rd_data
  );

endinterface

// ==== verilog/frag_dispatch.sv ====
`timescale 1ns/1ps

module frag_dispatch #(
  parameter int N_LANES = 2
) (
  input  logic               PLB_clk,
  input  logic               rst,
  input  fbw_pkg::frag_u     fifo_data,
  input  logic               fifo_empty,
  output logic               fifo_rd_en,
  input  logic [N_LANES-1:0] lane_idle,
  output logic [N_LANES-1:0] lane_start,
  output fbw_pkg::pix_frag_t lane_frag,
  input  logic               flush_busy,
  output logic               flush_start
);
  import fbw_pkg::*;

  localparam int SEL_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  logic             rd_q;
  logic             pending;
  frag_u            hold;
  logic             is_flush;
  logic [SEL_W-1:0] lane_sel;

  ////////////////////////////////////////
  // FIFO pop and capture

  always_ff @(posedge PLB_clk) begin
    if (rst) begin
      fifo_rd_en <= 1'b0;
      rd_q       <= 1'b0;
      pending    <= 1'b0;
    end else begin
      // Single pop, then wait until the word is handed off
      fifo_rd_en <= !fifo_empty && !fifo_rd_en && !rd_q && !pending;
      rd_q       <= fifo_rd_en;
      if (rd_q) begin
        pending <= 1'b1;
      end else if (flush_start || (|lane_start)) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge PLB_clk) begin
    if (rd_q) begin
      hold <= fifo_data;
    end
  end

  ////////////////////////////////////////
  // Decode and steer

  assign is_flush  = (hold.marker == FLUSH_MARKER);
  // Column low bits keep one pixel in one lane
  assign lane_sel  = SEL_W'(hold.pix.col % N_LANES);
  assign lane_frag = hold.pix;

  assign flush_start = pending && is_flush && (&lane_idle) && !flush_busy;

  for (genvar i = 0; i < N_LANES; i++) begin : g_start
    assign lane_start[i] = pending && !is_flush && lane_idle[i] &&
                           (lane_sel == SEL_W'(i));
  end

  a_no_pop_pending: assert property (@(posedge PLB_clk) disable iff (rst)
    pending |-> !fifo_rd_en);

endmodule

// ==== verilog/zpix_lane.sv ====
`timescale 1ns/1ps

module zpix_lane #(
  parameter logic [8:0] FB_BASE_ADDR = 9'b1001_0000_0
) (
  input  logic               PLB_clk,
  input  logic               rst,
  input  logic               start,
  input  fbw_pkg::pix_frag_t frag,
  input  logic               buf_sel,
  output logic               idle,
  fbw_bus_if.requester       bus
);
  import fbw_pkg::*;

  lane_state_e state;
  pix_frag_t   frag_q;
  logic        z_plane;
  logic        depth_pass;

  assign idle = (state == LANE_IDLE);

  always_ff @(posedge PLB_clk) begin
    if (start && idle) begin
      frag_q <= frag;
    end
  end

  ////////////////////////////////////////
  // Read z, then color and z on a pass

  always_ff @(posedge PLB_clk) begin
    if (rst) begin
      state      <= LANE_IDLE;
      bus.rd_req <= 1'b0;
      bus.wr_req <= 1'b0;
    end else begin
      if (bus.cmd_ack) begin
        bus.rd_req <= 1'b0;
        bus.wr_req <= 1'b0;
      end
      case (state)
        LANE_IDLE: begin
          if (start) begin
            state      <= LANE_RD_Z;
            bus.rd_req <= 1'b1;
          end
        end
        LANE_RD_Z: begin
          if (bus.cmplt) begin
            if (depth_pass) begin
              state      <= LANE_WR_FB;
              bus.wr_req <= 1'b1;
            end else begin
              state <= LANE_IDLE;
            end
          end
        end
        LANE_WR_FB: begin
          if (bus.cmplt) begin
            state      <= LANE_WR_Z;
            bus.wr_req <= 1'b1;
          end
        end
        default: begin
          if (bus.cmplt) begin
            state <= LANE_IDLE;
          end
        end
      endcase
    end
  end

  // Stored depth is only valid with cmplt
  assign depth_pass = (frag_q.depth <= bus.rd_data);

  assign z_plane     = (state != LANE_WR_FB);
  assign bus.addr    = {FB_BASE_ADDR, buf_sel, z_plane, frag_q.line, frag_q.col, 2'b00};
  assign bus.wr_data = (state == LANE_WR_FB) ? frag_q.color : frag_q.depth;

  a_start_when_idle: assert property (@(posedge PLB_clk) disable iff (rst)
    start |-> idle);

endmodule

// ==== verilog/flush_seq.sv ====
`timescale 1ns/1ps

module flush_seq #(
  parameter logic [8:0]         FB_BASE_ADDR  = 9'b1001_0000_0,
  parameter fbw_pkg::fbw_addr_t FB_CNTL_ADDR  = 32'h40A0_8000,
  parameter fbw_pkg::fbw_addr_t DMA_CNTL_ADDR = 32'hC000_0000
) (
  input  logic         PLB_clk,
  input  logic         rst,
  input  logic         flush_start,
  output logic         flush_busy,
  output logic         buf_sel,
  fbw_bus_if.requester bus
);
  import fbw_pkg::*;

  localparam int IDX_W = $clog2(FLUSH_WORDS);

  logic [IDX_W-1:0] word_idx;
  logic             last_word;

  assign last_word = (word_idx == IDX_W'(FLUSH_WORDS - 1));

  always_ff @(posedge PLB_clk) begin
    if (rst) begin
      flush_busy <= 1'b0;
      buf_sel    <= 1'b0;
      word_idx   <= '0;
      bus.wr_req <= 1'b0;
    end else begin
      if (bus.cmd_ack) begin
        bus.wr_req <= 1'b0;
      end
      if (flush_start && !flush_busy) begin
        flush_busy <= 1'b1;
        word_idx   <= '0;
        bus.wr_req <= 1'b1;
      end else if (flush_busy && bus.cmplt) begin
        if (last_word) begin
          // Swap front and back buffer
          flush_busy <= 1'b0;
          buf_sel    <= ~buf_sel;
        end else begin
          word_idx   <= word_idx + 1'b1;
          bus.wr_req <= 1'b1;
        end
      end
    end
  end

  assign bus.rd_req = 1'b0;

  ////////////////////////////////////////
  // Display reg, then DMA src, dst, len

  always_comb begin
    case (word_idx)
      IDX_W'(0): begin
        bus.addr    = FB_CNTL_ADDR;
        bus.wr_data = {FB_BASE_ADDR, ~buf_sel, 22'b0};
      end
      IDX_W'(1): begin
        bus.addr    = DMA_CNTL_ADDR + 32'd8;
        bus.wr_data = {FB_BASE_ADDR + 9'd1, 1'b1, 22'b0};
      end
      IDX_W'(2): begin
        bus.addr    = DMA_CNTL_ADDR + 32'd12;
        bus.wr_data = {FB_BASE_ADDR, buf_sel, 22'b0};
      end
      default: begin
        bus.addr    = DMA_CNTL_ADDR + 32'd16;
        bus.wr_data = 32'h0040_0000;
      end
    endcase
  end

endmodule

// ==== verilog/plb_master_arb.sv ====
`timescale 1ns/1ps

module plb_master_arb #(
  parameter int N_LANES = 2
) (
  input  logic               PLB_clk,
  input  logic               rst,
  fbw_bus_if.arbiter         req [N_LANES+1],
  output logic               mst_rd_req,
  output logic               mst_wr_req,
  output fbw_pkg::fbw_addr_t mst_addr,
  output fbw_pkg::fbw_word_t mst_wr_data,
  input  logic               mst_cmd_ack,
  input  logic               mst_cmplt,
  input  fbw_pkg::fbw_word_t mst_rd_data
);
  import fbw_pkg::*;

  localparam int N_REQ = N_LANES + 1;
  localparam int IDX_W = $clog2(N_REQ);

  logic [N_REQ-1:0] req_rd;
  logic [N_REQ-1:0] req_wr;
  fbw_addr_t        req_addr [N_REQ];
  fbw_word_t        req_data [N_REQ];
  logic [N_REQ-1:0] grant;
  logic [IDX_W-1:0] last;
  logic [IDX_W-1:0] pick_idx;
  logic             found;

  for (genvar i = 0; i < N_REQ; i++) begin : g_port
    assign req_rd[i]      = req[i].rd_req;
    assign req_wr[i]      = req[i].wr_req;
    assign req_addr[i]    = req[i].addr;
    assign req_data[i]    = req[i].wr_data;
    assign req[i].cmd_ack = grant[i] & mst_cmd_ack;
    assign req[i].cmplt   = grant[i] & mst_cmplt;
    assign req[i].rd_data = grant[i] ? mst_rd_data : '0;
  end

  ////////////////////////////////////////
  // Round robin, starting after last winner

  always_comb begin
    int idx;
    found    = 1'b0;
    pick_idx = '0;
    for (int k = 1; k <= N_REQ; k++) begin
      idx = (int'(last) + k) % N_REQ;
      if (!found && (req_rd[idx] || req_wr[idx])) begin
        found    = 1'b1;
        pick_idx = IDX_W'(idx);
      end
    end
  end

  always_ff @(posedge PLB_clk) begin
    if (rst) begin
      grant <= '0;
      last  <= IDX_W'(N_REQ - 1);
    end else if (|grant) begin
      if (mst_cmplt) begin
        grant <= '0;
      end
    end else if (found) begin
      grant <= N_REQ'(1) << pick_idx;
      last  <= pick_idx;
    end
  end

  always_comb begin
    mst_rd_req  = 1'b0;
    mst_wr_req  = 1'b0;
    mst_addr    = '0;
    mst_wr_data = '0;
    for (int i = 0; i < N_REQ; i++) begin
      if (grant[i]) begin
        mst_rd_req  = req_rd[i];
        mst_wr_req  = req_wr[i];
        mst_addr    = req_addr[i];
        mst_wr_data = req_data[i];
      end
    end
  end

  a_grant_onehot: assert property (@(posedge PLB_clk) disable iff (rst)
    $onehot0(grant));

  a_rd_wr_excl: assert property (@(posedge PLB_clk) disable iff (rst)
    !(mst_rd_req && mst_wr_req));

endmodule

// ==== verilog/fb_writer_top.sv ====
`timescale 1ns/1ps

module fb_writer_top #(
  parameter int                 N_LANES       = 2,
  parameter logic [8:0]         FB_BASE_ADDR  = 9'b1001_0000_0,
  parameter fbw_pkg::fbw_addr_t FB_CNTL_ADDR  = 32'h40A0_8000,
  parameter fbw_pkg::fbw_addr_t DMA_CNTL_ADDR = 32'hC000_0000
) (
  input  logic               PLB_clk,
  input  logic               rst,
  input  fbw_pkg::frag_u     fifo_data,
  input  logic               fifo_empty,
  output logic               fifo_rd_en,
  output logic               mst_rd_req,
  output logic               mst_wr_req,
  output fbw_pkg::fbw_addr_t mst_addr,
  output fbw_pkg::fbw_word_t mst_wr_data,
  input  logic               mst_cmd_ack,
  input  logic               mst_cmplt,
  input  fbw_pkg::fbw_word_t mst_rd_data
);
  import fbw_pkg::*;

  logic [N_LANES-1:0] lane_idle;
  logic [N_LANES-1:0] lane_start;
  pix_frag_t          lane_frag;
  logic               flush_busy;
  logic               flush_start;
  logic               buf_sel;

  // Lanes first, flush sequencer on the last index
  fbw_bus_if bus_if [N_LANES+1] ();

  frag_dispatch #(.N_LANES(N_LANES)) u_dispatch (
    .PLB_clk(PLB_clk), .rst(rst),
    .fifo_data(fifo_data), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
    .lane_idle(lane_idle), .lane_start(lane_start), .lane_frag(lane_frag),
    .flush_busy(flush_busy), .flush_start(flush_start)
  );

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    zpix_lane #(.FB_BASE_ADDR(FB_BASE_ADDR)) u_lane (
      .PLB_clk(PLB_clk), .rst(rst), .start(lane_start[i]), .frag(lane_frag),
      .buf_sel(buf_sel), .idle(lane_idle[i]), .bus(bus_if[i])
    );
  end

  flush_seq #(
    .FB_BASE_ADDR(FB_BASE_ADDR), .FB_CNTL_ADDR(FB_CNTL_ADDR), .DMA_CNTL_ADDR(DMA_CNTL_ADDR)
  ) u_flush (
    .PLB_clk(PLB_clk), .rst(rst), .flush_start(flush_start),
    .flush_busy(flush_busy), .buf_sel(buf_sel), .bus(bus_if[N_LANES])
  );

  plb_master_arb #(.N_LANES(N_LANES)) u_arb (
    .PLB_clk(PLB_clk), .rst(rst), .req(bus_if),
    .mst_rd_req(mst_rd_req), .mst_wr_req(mst_wr_req),
    .mst_addr(mst_addr), .mst_wr_data(mst_wr_data),
    .mst_cmd_ack(mst_cmd_ack), .mst_cmplt(mst_cmplt), .mst_rd_data(mst_rd_data)
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic PLB_clk,
  output logic rst
);

  initial begin
    PLB_clk = 1'b0;
    forever #4 PLB_clk = ~PLB_clk;
  end

  // Reset held for 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge PLB_clk);
    rst <= 1'b0;
  end

endmodule

// ==== verification/tb_bus_model.sv ====
`timescale 1ns/1ps

module tb_bus_model (
  input  logic               PLB_clk,
  input  logic               rst,
  input  logic               mst_rd_req,
  input  logic               mst_wr_req,
  input  fbw_pkg::fbw_addr_t mst_addr,
  input  fbw_pkg::fbw_word_t mst_wr_data,
  output logic               mst_cmd_ack,
  output logic               mst_cmplt,
  output fbw_pkg::fbw_word_t mst_rd_data
);
  import fbw_pkg::*;

  fbw_word_t mem [fbw_addr_t];
  fbw_addr_t wr_log_addr [$];

  logic [31:0] lfsr = 32'h99af877d;
  logic [1:0]  phase = 2'd0;
  int          wait_cnt = 0;
  fbw_word_t   rd_word;

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Mostly a short wait and now and then a long stall
  function automatic int pick_delay();
    int d;
    d = int'(next_bits(3));
    if (next_bits(3) == 0) begin
      d = d + 40;
    end
    return d;
  endfunction

  initial begin
    mst_cmd_ack = 1'b0;
    mst_cmplt   = 1'b0;
    mst_rd_data = '0;
  end

  ////////////////////////////////////////
  // Idle, ack wait, cmplt wait, done

  always @(posedge PLB_clk) begin
    if (rst) begin
      phase       <= 2'd0;
      mst_cmd_ack <= 1'b0;
      mst_cmplt   <= 1'b0;
      mst_rd_data <= '0;
    end else begin
      case (phase)
        2'd0: begin
          if (mst_rd_req || mst_wr_req) begin
            wait_cnt = pick_delay();
            phase    <= 2'd1;
          end
        end
        2'd1: begin
          if (wait_cnt == 0) begin
            mst_cmd_ack <= 1'b1;
            if (mst_wr_req) begin
              mem[mst_addr] = mst_wr_data;
              wr_log_addr.push_back(mst_addr);
            end else begin
              // Unwritten depth reads as farthest
              rd_word = mem.exists(mst_addr) ? mem[mst_addr] : '1;
            end
            wait_cnt = pick_delay();
            phase    <= 2'd2;
          end else begin
            wait_cnt = wait_cnt - 1;
          end
        end
        2'd2: begin
          mst_cmd_ack <= 1'b0;
          if (wait_cnt == 0) begin
            mst_cmplt   <= 1'b1;
            mst_rd_data <= rd_word;
            phase       <= 2'd3;
          end else begin
            wait_cnt = wait_cnt - 1;
          end
        end
        default: begin
          mst_cmplt   <= 1'b0;
          mst_rd_data <= '0;
          phase       <= 2'd0;
        end
      endcase
    end
  end

endmodule

// ==== verification/tb_fb_writer.sv ====
`timescale 1ns/1ps

module tb_fb_writer;
  import fbw_pkg::*;

  localparam int         N_LANES  = 2;
  localparam int         TBL_LEN  = 14;
  localparam logic [8:0] FB_BASE  = 9'b1001_0000_0;
  localparam fbw_addr_t  FB_CNTL  = 32'h40A0_8000;
  localparam fbw_addr_t  DMA_CNTL = 32'hC000_0000;

  typedef struct packed {
    frag_u frag;
    logic  draw;
  } entry_t;

  typedef struct packed {
    logic      wr;
    fbw_addr_t addr;
    fbw_word_t data;
    logic      buf_exp;
    int        seg;
  } exp_t;

  logic      PLB_clk;
  logic      rst;
  frag_u     fifo_data = '0;
  logic      fifo_empty = 1'b1;
  logic      fifo_rd_en;
  logic      mst_rd_req;
  logic      mst_wr_req;
  fbw_addr_t mst_addr;
  fbw_word_t mst_wr_data;
  logic      mst_cmd_ack;
  logic      mst_cmplt;
  fbw_word_t mst_rd_data;

  entry_t    tbl [TBL_LEN];
  exp_t      lane_q [N_LANES][$];
  exp_t      flush_q [$];
  fbw_word_t ref_mem [fbw_addr_t];
  logic      ref_buf;
  logic [31:0] lfsr = 32'h99af877d;
  int        ptr = 0;
  int        flushes_served = 0;
  int        flush_words_done = 0;
  int        z_reads = 0;
  int        n_pix = 0;
  int        n_flush = 0;
  int        cycles = 0;
  logic      last_flush = 1'b0;

  tb_clk_gen u_clk (.PLB_clk(PLB_clk), .rst(rst));

  fb_writer_top #(
    .N_LANES(N_LANES), .FB_BASE_ADDR(FB_BASE), .FB_CNTL_ADDR(FB_CNTL), .DMA_CNTL_ADDR(DMA_CNTL)
  ) DUT (
    .PLB_clk(PLB_clk), .rst(rst),
    .fifo_data(fifo_data), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
    .mst_rd_req(mst_rd_req), .mst_wr_req(mst_wr_req),
    .mst_addr(mst_addr), .mst_wr_data(mst_wr_data),
    .mst_cmd_ack(mst_cmd_ack), .mst_cmplt(mst_cmplt), .mst_rd_data(mst_rd_data)
  );

  tb_bus_model u_bus (
    .PLB_clk(PLB_clk), .rst(rst),
    .mst_rd_req(mst_rd_req), .mst_wr_req(mst_wr_req),
    .mst_addr(mst_addr), .mst_wr_data(mst_wr_data),
    .mst_cmd_ack(mst_cmd_ack), .mst_cmplt(mst_cmplt), .mst_rd_data(mst_rd_data)
  );

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Compare and failure reporting

  task automatic fail_plain(input string what);
    $display("%s at %0t", what, $time);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input fbw_addr_t got, input fbw_addr_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input fbw_word_t got, input fbw_word_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table and reference model

  task automatic put_pix(input int i, input line_t ln, input col_t cl,
                         input fbw_word_t color, input fbw_word_t depth);
    frag_u f;
    f.pix.pad_line = '0;
    f.pix.line     = ln;
    f.pix.pad_col  = '0;
    f.pix.col      = cl;
    f.pix.color    = color;
    f.pix.depth    = depth;
    tbl[i].frag    = f;
    tbl[i].draw    = 1'b0;
  endtask

  task automatic put_flush(input int i);
    tbl[i].frag.marker = '1;
    tbl[i].draw        = 1'b0;
  endtask

  task automatic push_flush(input fbw_addr_t a, input fbw_word_t d, input int seg);
    flush_q.push_back('{wr: 1'b1, addr: a, data: d, buf_exp: ref_buf, seg: seg});
  endtask

  task automatic build_expected();
    int        seg;
    int        ln;
    fbw_addr_t za;
    fbw_addr_t fa;
    fbw_word_t stored;
    pix_frag_t p;
    seg     = 0;
    ref_buf = 1'b0;
    for (int i = 0; i < TBL_LEN; i++) begin
      if (tbl[i].frag.marker == '1) begin
        push_flush(FB_CNTL, {FB_BASE, ~ref_buf, 22'b0}, seg);
        push_flush(DMA_CNTL + 32'd8, {FB_BASE + 9'd1, 1'b1, 22'b0}, seg);
        push_flush(DMA_CNTL + 32'd12, {FB_BASE, ref_buf, 22'b0}, seg);
        push_flush(DMA_CNTL + 32'd16, 32'h0040_0000, seg);
        seg     = seg + 1;
        ref_buf = ~ref_buf;
        n_flush = n_flush + 1;
      end else begin
        p      = tbl[i].frag.pix;
        ln     = int'(p.col) % N_LANES;
        za     = {FB_BASE, ref_buf, 1'b1, p.line, p.col, 2'b00};
        fa     = {FB_BASE, ref_buf, 1'b0, p.line, p.col, 2'b00};
        stored = ref_mem.exists(za) ? ref_mem[za] : '1;
        lane_q[ln].push_back('{wr: 1'b0, addr: za, data: '0, buf_exp: ref_buf, seg: seg});
        n_pix = n_pix + 1;
        // Closer or equal depth wins
        if (p.depth <= stored) begin
          tbl[i].draw = 1'b1;
          ref_mem[fa] = p.color;
          ref_mem[za] = p.depth;
          lane_q[ln].push_back('{wr: 1'b1, addr: fa, data: p.color, buf_exp: ref_buf, seg: seg});
          lane_q[ln].push_back('{wr: 1'b1, addr: za, data: p.depth, buf_exp: ref_buf, seg: seg});
        end
      end
    end
  endtask

  initial begin
    fbw_word_t d0;
    fbw_word_t d1;
    d0 = next_bits(31);
    put_pix(0, 9'd10, 10'd4, 32'hff00_1100, d0);
    put_pix(1, 9'd10, 10'd5, 32'h00ff_2200, next_bits(31));
    put_pix(2, 9'd10, 10'd4, 32'hdead_0001, d0 + 1);
    put_pix(3, 9'd10, 10'd4, 32'h0000_ff33, d0);
    put_pix(4, 9'd3, 10'd7, 32'h1234_5678, next_bits(32));
    put_pix(5, 9'd200, 10'd1023, 32'h8765_4321, next_bits(32));
    put_flush(6);
    d1 = next_bits(31);
    put_pix(7, 9'd10, 10'd4, 32'h5555_aaaa, d1);
    put_pix(8, 9'd10, 10'd4, 32'h6666_0000, d1 + 5);
    put_pix(9, 9'd3, 10'd6, 32'h0bad_cafe, next_bits(32));
    put_flush(10);
    put_pix(11, 9'd10, 10'd4, 32'h7777_7777, next_bits(32));
    put_pix(12, 9'd10, 10'd5, 32'hffff_0000, 32'hffff_ffff);
    put_flush(13);
    build_expected();
  end

  ////////////////////////////////////////
  // FIFO model held empty during a buffer swap

  always @(posedge PLB_clk) begin
    int next_ptr;
    int next_served;
    next_ptr    = ptr;
    next_served = flushes_served;
    if (!rst && fifo_rd_en) begin
      if (fifo_empty || ptr >= TBL_LEN) begin
        fail_plain("FIFO popped while empty");
      end else begin
        fifo_data <= tbl[ptr].frag;
        if (tbl[ptr].frag.marker == '1) begin
          next_served = next_served + 1;
        end
        next_ptr = next_ptr + 1;
      end
    end
    ptr            <= next_ptr;
    flushes_served <= next_served;
    fifo_empty     <= rst || (next_ptr >= TBL_LEN) || (flush_words_done < 4 * next_served);
  end

  ////////////////////////////////////////
  // Bus monitor

  task automatic check_txn(input logic rd, input logic wr, input fbw_addr_t a,
                           input fbw_word_t d);
    exp_t e;
    int   ln;
    if (a[31:23] == FB_BASE) begin
      last_flush = 1'b0;
      ln = int'(a[11:2]) % N_LANES;
      if (lane_q[ln].size() == 0) begin
        fail_plain("Unexpected pixel transaction on the bus");
      end
      e = lane_q[ln].pop_front();
      check_bit("mst_wr_req", wr, e.wr);
      check_bit("mst_rd_req", rd, ~e.wr);
      check_addr("mst_addr", a, e.addr);
      if (wr) begin
        check_word("mst_wr_data", d, e.data);
      end else begin
        z_reads = z_reads + 1;
      end
    end else begin
      last_flush = 1'b1;
      if (flush_q.size() == 0) begin
        fail_plain("Unexpected control write on the bus");
      end
      e = flush_q.pop_front();
      if (a == FB_CNTL) begin
        for (int l = 0; l < N_LANES; l++) begin
          if (lane_q[l].size() != 0 && lane_q[l][0].seg <= e.seg) begin
            fail_plain("Pixel transaction still pending when the flush began");
          end
        end
        check_bit("buf_sel", DUT.buf_sel, e.buf_exp);
        check_bit("fb_cntl buffer bit", d[22], ~e.buf_exp);
      end
      check_bit("mst_wr_req", wr, 1'b1);
      check_bit("mst_rd_req", rd, 1'b0);
      check_addr("mst_addr", a, e.addr);
      check_word("mst_wr_data", d, e.data);
    end
  endtask

  always @(posedge PLB_clk) begin
    if (!rst) begin
      if (mst_cmd_ack) begin
        check_txn(mst_rd_req, mst_wr_req, mst_addr, mst_wr_data);
      end
      if (mst_cmplt && last_flush) begin
        flush_words_done <= flush_words_done + 1;
      end
    end
  end

  always @(posedge PLB_clk) begin
    cycles <= cycles + 1;
    if (cycles >= 400 * TBL_LEN) begin
      $display("Timeout: the run did not finish within %0d cycles", 400 * TBL_LEN);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // End of run

  initial begin
    int n_draw;
    n_draw = 0;
    @(negedge rst);
    while (!(ptr == TBL_LEN && flush_words_done == 4 * n_flush &&
             lane_q[0].size() == 0 && lane_q[1].size() == 0)) begin
      @(posedge PLB_clk);
    end
    @(posedge PLB_clk);
    foreach (tbl[i]) begin
      if (tbl[i].draw) begin
        n_draw = n_draw + 1;
      end
    end
    check_word("z reads", fbw_word_t'(z_reads), fbw_word_t'(n_pix));
    check_word("logged writes", fbw_word_t'(u_bus.wr_log_addr.size()),
               fbw_word_t'(2 * n_draw + 4 * n_flush));
    foreach (ref_mem[a]) begin
      check_word($sformatf("mem[%h]", a), u_bus.mem[a], ref_mem[a]);
    end
    check_bit("buf_sel", DUT.buf_sel, ref_buf);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
verilog/fbw_pkg.sv
verilog/fbw_bus_if.sv
verilog/frag_dispatch.sv
verilog/zpix_lane.sv
verilog/flush_seq.sv
verilog/plb_master_arb.sv
verilog/fb_writer_top.sv
verification/tb_clk_gen.sv
verification/tb_bus_model.sv
verification/tb_fb_writer.sv

// ==== Bender.yml ====
package:
  name: fb_writer

sources:
  - verilog/fbw_pkg.sv
  - verilog/fbw_bus_if.sv
  - verilog/frag_dispatch.sv
  - verilog/zpix_lane.sv
  - verilog/flush_seq.sv
  - verilog/plb_master_arb.sv
  - verilog/fb_writer_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_bus_model.sv
      - verification/tb_fb_writer.sv
